// File: riscvCore.f
verilog/riscvPkg.sv
verilog/controller.sv
verilog/immGen.sv
verilog/regFile.sv
verilog/alu.sv
verilog/memIoBridge.sv
verilog/ecallUnit.sv
verilog/riscvCore.sv
tests/riscvCoreTb.sv

// File: Bender.yml
package:
  name: riscvCore

sources:
  - verilog/riscvPkg.sv
  - verilog/controller.sv
  - verilog/immGen.sv
  - verilog/regFile.sv
  - verilog/alu.sv
  - verilog/memIoBridge.sv
  - verilog/ecallUnit.sv
  - verilog/riscvCore.sv
  - target: test
    files:
      - tests/riscvCoreTb.sv

// File: tests/riscvCoreTb.sv
`timescale 1ns/1ps

module riscvCoreTb import riscvPkg::*; ();

    localparam int RAM_WORDS       = 256;
    localparam int CONSOLE_CREDITS = 4;
    localparam int ROM_WORDS       = 256;
    // Five programs of under 40 instructions, 8 reset cycles each,
    // plus a 30 cycle credit window and a 20 cycle halt watch
    localparam int CYCLE_LIMIT     = 4000;

    localparam regAddr LED_BASE    = 5'd5;
    localparam word    ECALL_WORD  = {INST_ECALL, 13'd0, OPCODE_E};
    localparam word    EBREAK_WORD = {INST_EBREAK, 13'd0, OPCODE_E};

    logic       clk;
    logic       rst;
    word        instAddr;
    word        instData;
    word        switches;
    word        leds;
    consoleBeat txBeat;
    logic       txCredit;
    consoleBeat rxBeat;
    logic       rxCredit;
    logic       halted;

    // Instruction ROM, past the program end it reads EBREAK
    word rom [ROM_WORDS];
    int  progLen;

    // Host side models
    bit  rstQ = 1'b1;
    bit  holdCredits;
    bit  ledStorePending;
    int  txOutstanding;
    int  hostCredits;
    int  rxConsumed;
    word ledLog [$];
    word expLeds [$];
    word txLog [$];
    word expTx [$];
    word rxPending [$];

    int cycles;
    int checks;
    int errors;

    assign instData = (instAddr[31:2] < progLen) ? rom[instAddr[9:2]] : EBREAK_WORD;

    riscvCore #(
        .RAM_WORDS(RAM_WORDS),
        .CONSOLE_CREDITS(CONSOLE_CREDITS)
    ) i_riscvCore (
        .clk(clk), .rst(rst), .instAddr(instAddr), .instData(instData),
        .switches(switches), .leds(leds), .txBeat(txBeat), .txCredit(txCredit),
        .rxBeat(rxBeat), .rxCredit(rxCredit), .halted(halted)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ------------------------------------------------------------------------
    // Checks
    // ------------------------------------------------------------------------
    task automatic checkWord(input string name, input word got, input word exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("Error at %0t ns: %s = 0x%08h, expected 0x%08h", $time, name, got, exp);
        end
    endtask

    task automatic checkTrue(input bit cond, input string what);
        checks++;
        assert (cond) else begin
            errors++;
            $display("Failure at %0t ns: %s", $time, what);
        end
    endtask

    task automatic compareLeds(input string test);
        checkTrue(ledLog.size() == expLeds.size(), {test, ": wrong number of LED writes"});
        for (int i = 0; i < expLeds.size() && i < ledLog.size(); i++) begin
            checkWord($sformatf("%s leds[%0d]", test, i), ledLog[i], expLeds[i]);
        end
    endtask

    task automatic compareTx(input string test);
        checkTrue(txLog.size() == expTx.size(), {test, ": wrong number of console beats"});
        for (int i = 0; i < expTx.size() && i < txLog.size(); i++) begin
            checkWord($sformatf("%s txBeat.data[%0d]", test, i), txLog[i], expTx[i]);
        end
    endtask

    // ------------------------------------------------------------------------
    // Instruction encoders
    // ------------------------------------------------------------------------
    function automatic word encR(input logic [6:0] f7, input regAddr rs2, input regAddr rs1,
                                 input logic [2:0] f3, input regAddr rd);
        return {f7, rs2, rs1, f3, rd, OPCODE_R};
    endfunction

    function automatic word encI(input word imm, input regAddr rs1, input logic [2:0] f3,
                                 input regAddr rd, input logic [6:0] op);
        return {imm[11:0], rs1, f3, rd, op};
    endfunction

    // Word store only
    function automatic word encS(input word imm, input regAddr rs2, input regAddr rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OPCODE_S};
    endfunction

    // BEQ, byte offset
    function automatic word encB(input word off, input regAddr rs2, input regAddr rs1);
        return {off[12], off[10:5], rs2, rs1, 3'b000, off[4:1], off[11], OPCODE_B};
    endfunction

    function automatic word encJ(input word off, input regAddr rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, OPCODE_JAL};
    endfunction

    function automatic word encU(input logic [19:0] upper, input regAddr rd,
                                 input logic [6:0] op);
        return {upper, rd, op};
    endfunction

    task automatic emit(input word inst);
        rom[progLen] = inst;
        progLen++;
    endtask

    // LUI plus ADDI, upper part rounded for the signed low half
    task automatic loadConst(input regAddr rd, input word value);
        word upper;
        upper = (value + 32'h800) >> 12;
        emit(encU(upper[19:0], rd, OPCODE_LUI));
        emit(encI(value, rd, 3'b000, rd, OPCODE_I));
    endtask

    task automatic storeLed(input regAddr rs);
        emit(encS(32'd0, rs, LED_BASE));
    endtask

    // x8 = x6 op x7, then out to the LEDs
    task automatic rOpToLeds(input logic [6:0] f7, input logic [2:0] f3);
        emit(encR(f7, 5'd7, 5'd6, f3, 5'd8));
        storeLed(5'd8);
    endtask

    // ------------------------------------------------------------------------
    // Sequencing
    // ------------------------------------------------------------------------
    task automatic beginReset();
        @(negedge clk);
        rst = 1'b1;
        @(posedge clk);
        progLen = 0;
        rxConsumed = 0;
        ledLog.delete();
        expLeds.delete();
        txLog.delete();
        expTx.delete();
        rxPending.delete();
    endtask

    task automatic endReset();
        repeat (8) @(negedge clk);
        rst = 1'b0;
    endtask

    task automatic waitHalted();
        while (!halted) begin
            @(negedge clk);
        end
    endtask

    // Bus monitor, sampled before the edge updates anything
    always @(posedge clk) begin
        rstQ = rst;
        if (rst) begin
            txOutstanding = 0;
            ledStorePending = 1'b0;
        end else begin
            if (txBeat.valid) begin
                txLog.push_back(txBeat.data);
                txOutstanding++;
            end
            if (txCredit) begin
                txOutstanding--;
            end
            checkTrue(txOutstanding <= CONSOLE_CREDITS, "console beat sent without a credit");
            if (rxCredit) begin
                hostCredits++;
                rxConsumed++;
            end
            // Store through the LED base register
            ledStorePending = !halted && instData[6:0] == OPCODE_S &&
                              instData[19:15] == LED_BASE;
        end
    end

    // Credit return, host RX sender, LED capture
    always @(negedge clk) begin
        if (ledStorePending) begin
            ledLog.push_back(leds);
            ledStorePending = 1'b0;
        end
        if (rstQ) begin
            txCredit = 1'b0;
            rxBeat = '0;
            hostCredits = CONSOLE_CREDITS;
        end else begin
            txCredit = !holdCredits && txOutstanding > 0;
            if (rxPending.size() > 0 && hostCredits > 0) begin
                rxBeat.valid = 1'b1;
                rxBeat.data = rxPending.pop_front();
                hostCredits--;
            end else begin
                rxBeat = '0;
            end
        end
    end

    // ------------------------------------------------------------------------
    // Tests
    // ------------------------------------------------------------------------
    task automatic testAlu();
        word a;
        word b;
        beginReset();
        a = $urandom();
        b = $urandom();
        emit(encI(-32'sd1024, 5'd0, 3'b000, LED_BASE, OPCODE_I));
        loadConst(5'd6, a);
        loadConst(5'd7, b);
        rOpToLeds(7'h00, 3'b000);
        expLeds.push_back(a + b);
        rOpToLeds(7'h20, 3'b000);
        expLeds.push_back(a - b);
        rOpToLeds(7'h00, 3'b111);
        expLeds.push_back(a & b);
        rOpToLeds(7'h00, 3'b110);
        expLeds.push_back(a | b);
        rOpToLeds(7'h00, 3'b100);
        expLeds.push_back(a ^ b);
        rOpToLeds(7'h00, 3'b010);
        expLeds.push_back(($signed(a) < $signed(b)) ? 32'd1 : 32'd0);
        rOpToLeds(7'h00, 3'b001);
        expLeds.push_back(a << b[4:0]);
        rOpToLeds(7'h00, 3'b101);
        expLeds.push_back(a >> b[4:0]);
        rOpToLeds(7'h20, 3'b101);
        expLeds.push_back(word'($signed(a) >>> b[4:0]));
        // SRAI 13 and a negative ADDI
        emit(encI(32'h40D, 5'd6, 3'b101, 5'd8, OPCODE_I));
        storeLed(5'd8);
        expLeds.push_back(word'($signed(a) >>> 13));
        emit(encI(-32'sd5, 5'd6, 3'b000, 5'd8, OPCODE_I));
        storeLed(5'd8);
        expLeds.push_back(a - 32'd5);
        emit(EBREAK_WORD);
        endReset();
        waitHalted();
        compareLeds("alu");
    endtask

    task automatic testMemFlow();
        word v1;
        word v2;
        beginReset();
        v1 = $urandom();
        v2 = v1 ^ 32'h0000_0100;
        emit(encI(-32'sd1024, 5'd0, 3'b000, LED_BASE, OPCODE_I));
        loadConst(5'd6, v1);
        loadConst(5'd7, v2);
        emit(encS(32'd16, 5'd6, 5'd0));
        emit(encS(32'd20, 5'd7, 5'd0));
        emit(encI(32'd16, 5'd0, 3'b010, 5'd8, OPCODE_L));
        // One full RAM past word 5, wraps back onto it
        emit(encI(32'd20 + RAM_WORDS * 4, 5'd0, 3'b010, 5'd9, OPCODE_L));
        storeLed(5'd8);
        storeLed(5'd9);
        expLeds.push_back(v1);
        expLeds.push_back(v2);
        // Not taken
        emit(encB(32'd8, 5'd9, 5'd8));
        storeLed(5'd8);
        expLeds.push_back(v1);
        // Taken, then JAL, each over a bad write
        emit(encB(32'd8, 5'd8, 5'd8));
        storeLed(5'd0);
        emit(encJ(32'd8, 5'd0));
        storeLed(5'd0);
        emit(encR(7'h00, 5'd9, 5'd8, 3'b000, 5'd10));
        storeLed(5'd10);
        expLeds.push_back(v1 + v2);
        // Call into a subroutine and return through x1
        emit(encJ(32'd16, 5'd1));
        emit(encI(32'h02A, 5'd0, 3'b000, 5'd12, OPCODE_I));
        storeLed(5'd12);
        emit(EBREAK_WORD);
        emit(encI(32'h155, 5'd0, 3'b000, 5'd11, OPCODE_I));
        storeLed(5'd11);
        emit(encI(32'd0, 5'd1, 3'b000, 5'd0, OPCODE_JALR));
        expLeds.push_back(32'h155);
        expLeds.push_back(32'h02A);
        endReset();
        waitHalted();
        compareLeds("memflow");
    endtask

    task automatic testPrint();
        word v;
        beginReset();
        holdCredits = 1'b1;
        emit(encI(32'd1, 5'd0, 3'b000, 5'd17, OPCODE_I));
        for (int i = 0; i < 8; i++) begin
            v = $urandom();
            expTx.push_back(v);
            loadConst(5'd10, v);
            emit(ECALL_WORD);
        end
        emit(EBREAK_WORD);
        endReset();
        while (txLog.size() < CONSOLE_CREDITS) begin
            @(negedge clk);
        end
        // No credit back, so no further beat may leave
        repeat (30) @(negedge clk);
        checkTrue(txLog.size() == CONSOLE_CREDITS, "beats sent beyond the credit limit");
        checkTrue(!halted, "program finished while console credits were withheld");
        @(posedge clk);
        holdCredits = 1'b0;
        waitHalted();
        compareTx("print");
    endtask

    task automatic testRead();
        word w;
        word sum;
        beginReset();
        sum = '0;
        for (int i = 0; i < 3; i++) begin
            w = $urandom();
            rxPending.push_back(w);
            sum = sum + w;
        end
        emit(encI(-32'sd1024, 5'd0, 3'b000, LED_BASE, OPCODE_I));
        emit(encI(32'd5, 5'd0, 3'b000, 5'd17, OPCODE_I));
        emit(ECALL_WORD);
        emit(encR(7'h00, 5'd10, 5'd0, 3'b000, 5'd6));
        emit(ECALL_WORD);
        emit(encR(7'h00, 5'd10, 5'd6, 3'b000, 5'd6));
        emit(ECALL_WORD);
        emit(encR(7'h00, 5'd10, 5'd6, 3'b000, 5'd6));
        storeLed(5'd6);
        emit(EBREAK_WORD);
        expLeds.push_back(sum);
        endReset();
        waitHalted();
        compareLeds("read");
        checkWord("rxCredit pulses", rxConsumed, 32'd3);
        checkWord("host RX credits", hostCredits, CONSOLE_CREDITS);
    endtask

    task automatic testHalt();
        word sw;
        beginReset();
        sw = $urandom();
        emit(encI(-32'sd1024, 5'd0, 3'b000, LED_BASE, OPCODE_I));
        emit(encI(32'd0, LED_BASE, 3'b010, 5'd6, OPCODE_L));
        storeLed(5'd6);
        emit(EBREAK_WORD);
        // Never reached
        storeLed(5'd0);
        emit(encI(32'd1, 5'd0, 3'b000, 5'd6, OPCODE_I));
        @(negedge clk);
        switches = sw;
        endReset();
        waitHalted();
        checkWord("leds", leds, sw);
        checkWord("instAddr", instAddr, 32'd12);
        repeat (20) begin
            @(negedge clk);
            checkWord("leds", leds, sw);
            checkWord("instAddr", instAddr, 32'd12);
            checkTrue(halted, "halted dropped without reset");
        end
        checkTrue(ledLog.size() == 1, "LED write count after halt is wrong");
    endtask

    // ------------------------------------------------------------------------
    // Run control
    // ------------------------------------------------------------------------
    always @(posedge clk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Checks: %0d, errors: %0d", checks, errors);
            $display("** FAIL **");
            $finish;
        end
    end

    initial begin
        rst = 1'b1;
        switches = '0;
        txCredit = 1'b0;
        rxBeat = '0;
        holdCredits = 1'b0;
        progLen = 0;
        cycles = 0;
        checks = 0;
        errors = 0;
        void'($urandom(54));
        testAlu();
        testMemFlow();
        testPrint();
        testRead();
        testHalt();
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// File: verilog/riscvCore.sv
`timescale 1ns/1ps

module riscvCore import riscvPkg::*; #(
    parameter int RAM_WORDS       = 256,
    parameter int CONSOLE_CREDITS = 4
) (
    input  logic       clk,
    input  logic       rst,
    output word        instAddr,
    input  word        instData,
    input  word        switches,
    output word        leds,
    output consoleBeat txBeat,
    input  logic       txCredit,
    input  consoleBeat rxBeat,
    output logic       rxCredit,
    output logic       halted
);

    ctrlSignals  ctrl;
    logic [11:0] ecallOp;
    logic [6:0]  opcode;
    word         pc;
    word         pcPlus4;
    word         pcImm;
    word         imm;
    word         rdata1;
    word         rdata2;
    word         a7;
    word         aluB;
    word         aluResult;
    logic        zero;
    logic        funct7b5;
    word         memData;
    word         readValue;
    word         wbData;
    regAddr      raddr1;
    regAddr      waddr;
    logic        stall;
    logic        commit;

    assign opcode   = instData[6:0];
    assign instAddr = pc;
    assign pcPlus4  = pc + 32'd4;
    assign pcImm    = pc + imm;

    // Nothing retires while stalled, halted or on EBREAK
    assign commit = !stall && !halted && !ctrl.eBreak;

    // ------------------------------------------------------------------------
    // Program counter and halt
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            pc     <= '0;
            halted <= 1'b0;
        end else begin
            if (ctrl.eBreak) begin
                halted <= 1'b1;
            end
            if (commit) begin
                if (ctrl.jalr) begin
                    pc <= (rdata1 + imm) & ~32'd1;
                end else if (ctrl.branch || ctrl.jump) begin
                    pc <= pcImm;
                end else begin
                    pc <= pcPlus4;
                end
            end
        end
    end

    // ------------------------------------------------------------------------
    // Register operands and write-back
    // ------------------------------------------------------------------------
    // ECALL reads and writes a0
    assign raddr1 = (opcode == OPCODE_E) ? regAddr'(10) : instData[19:15];
    assign waddr  = ctrl.eRead ? regAddr'(10) : instData[11:7];

    assign wbData = ctrl.eRead                 ? readValue :
                    (ctrl.jump || ctrl.jalr)   ? pcPlus4 :
                    (opcode == OPCODE_AUIPC)   ? pcImm :
                    ctrl.memToReg              ? memData : aluResult;

    // SUB and SRA only for R type or a right shift
    assign funct7b5 = instData[30] && (instData[5] || instData[14:12] == 3'b101);
    assign aluB     = ctrl.aluSrc ? imm : rdata2;

    controller i_controller (
        .inst(instData), .aluResult(aluResult), .zero(zero),
        .ecallCode(a7), .ctrl(ctrl), .ecallOp(ecallOp)
    );

    immGen i_immGen (.inst(instData), .imm(imm));

    regFile i_regFile (
        .clk(clk), .rst(rst), .raddr1(raddr1), .raddr2(instData[24:20]),
        .waddr(waddr), .wdata(wbData), .we((ctrl.regWrite || ctrl.eRead) && commit),
        .rdata1(rdata1), .rdata2(rdata2), .a7(a7)
    );

    alu i_alu (
        .aluOpClass(ctrl.aluOpClass), .funct3(instData[14:12]), .funct7b5(funct7b5),
        .a(rdata1), .b(aluB), .result(aluResult), .zero(zero)
    );

    memIoBridge #(.RAM_WORDS(RAM_WORDS)) i_memIoBridge (
        .clk(clk), .rst(rst), .addr(aluResult), .wdata(rdata2),
        .memRead(ctrl.memRead), .memWrite(ctrl.memWrite), .ioRead(ctrl.ioRead),
        .ioWrite(ctrl.ioWrite), .we(commit), .switches(switches),
        .rdata(memData), .leds(leds)
    );

    ecallUnit #(.CONSOLE_CREDITS(CONSOLE_CREDITS)) i_ecallUnit (
        .clk(clk), .rst(rst), .eRead(ctrl.eRead), .eWrite(ctrl.eWrite),
        .a0(rdata1), .txCredit(txCredit), .rxBeat(rxBeat), .txBeat(txBeat),
        .rxCredit(rxCredit), .readValue(readValue), .stall(stall)
    );

    // An ECALL must name a console service the core provides
    ecallKnown: assert property (@(posedge clk) disable iff (rst)
        (opcode == OPCODE_E && instData[31:20] == INST_ECALL && !halted) |->
            (ecallOp == EOP_PRINT_INT || ecallOp == EOP_READ_INT));

endmodule

// File: verilog/ecallUnit.sv
`timescale 1ns/1ps

module ecallUnit import riscvPkg::*; #(
    parameter int CONSOLE_CREDITS = 4
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       eRead,
    input  logic       eWrite,
    input  word        a0,
    input  logic       txCredit,
    input  consoleBeat rxBeat,
    output consoleBeat txBeat,
    output logic       rxCredit,
    output word        readValue,
    output logic       stall
);

    localparam int CW = $clog2(CONSOLE_CREDITS + 1);
    localparam int PW = $clog2(CONSOLE_CREDITS);

    logic [CW-1:0] txCount;
    logic [CW-1:0] rxCount;
    logic [PW-1:0] wrPtr;
    logic [PW-1:0] rdPtr;
    word           rxBuf [CONSOLE_CREDITS];
    logic          canSend;
    logic          send;
    logic          pop;

    // ------------------------------------------------------------------------
    // TX side
    // ------------------------------------------------------------------------
    // A credit returning this cycle is usable at once
    assign canSend = (txCount != '0) || txCredit;
    assign send    = eWrite && canSend;

    assign txBeat.valid = send;
    assign txBeat.data  = a0;

    always_ff @(posedge clk) begin
        if (rst) begin
            txCount <= CW'(CONSOLE_CREDITS);
        end else if (txCredit && !send && txCount != CW'(CONSOLE_CREDITS)) begin
            txCount <= txCount + 1'b1;
        end else if (send && !txCredit) begin
            txCount <= txCount - 1'b1;
        end
    end

    // ------------------------------------------------------------------------
    // RX side
    // ------------------------------------------------------------------------
    assign pop       = eRead && (rxCount != '0);
    assign rxCredit  = pop;
    assign readValue = rxBuf[rdPtr];

    always_ff @(posedge clk) begin
        if (rxBeat.valid) begin
            rxBuf[wrPtr] <= rxBeat.data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wrPtr   <= '0;
            rdPtr   <= '0;
            rxCount <= '0;
        end else begin
            if (rxBeat.valid) begin
                wrPtr <= (wrPtr == PW'(CONSOLE_CREDITS - 1)) ? '0 : wrPtr + 1'b1;
            end
            if (pop) begin
                rdPtr <= (rdPtr == PW'(CONSOLE_CREDITS - 1)) ? '0 : rdPtr + 1'b1;
            end
            if (rxBeat.valid && !pop) begin
                rxCount <= rxCount + 1'b1;
            end else if (pop && !rxBeat.valid) begin
                rxCount <= rxCount - 1'b1;
            end
        end
    end

    // Hold the ECALL until its direction is ready
    assign stall = (eWrite && !canSend) || (eRead && rxCount == '0);

    // A returned credit never lands on a full count
    txCap: assert property (@(posedge clk) disable iff (rst)
        (txCredit && !send) |-> (txCount != CW'(CONSOLE_CREDITS)));

    // Host keeps its credit count
    rxNoOverflow: assert property (@(posedge clk) disable iff (rst)
        rxBeat.valid |-> (rxCount != CW'(CONSOLE_CREDITS)));

endmodule

// File: verilog/memIoBridge.sv
`timescale 1ns/1ps

module memIoBridge import riscvPkg::*; #(
    parameter int RAM_WORDS = 256
) (
    input  logic clk,
    input  logic rst,
    input  word  addr,
    input  word  wdata,
    input  logic memRead,
    input  logic memWrite,
    input  logic ioRead,
    input  logic ioWrite,
    input  logic we,
    input  word  switches,
    output word  rdata,
    output word  leds
);

    localparam int AW = $clog2(RAM_WORDS);

    word ram [RAM_WORDS];
    logic [AW-1:0] idx;

    // Word index, wraps with a power-of-two depth
    assign idx = addr[AW+1:2];

    // Switches bypass the RAM
    assign rdata = ioRead  ? switches :
                   memRead ? ram[idx] : '0;

    always_ff @(posedge clk) begin
        if (memWrite && we) begin
            ram[idx] <= wdata;
        end
    end

    // LED register
    always_ff @(posedge clk) begin
        if (rst) begin
            leds <= '0;
        end else if (ioWrite && we) begin
            leds <= wdata;
        end
    end

    // Window decode keeps RAM and I/O apart
    ramIoExcl: assert property (@(posedge clk) disable iff (rst)
        !((memRead || memWrite) && (ioRead || ioWrite)));

endmodule

// File: verilog/alu.sv
`timescale 1ns/1ps

module alu import riscvPkg::*; (
    input  logic [1:0] aluOpClass,
    input  logic [2:0] funct3,
    input  logic       funct7b5,
    input  word        a,
    input  word        b,
    output word        result,
    output logic       zero
);

    aluOp op;

    // ------------------------------------------------------------------------
    // Operation select
    // ------------------------------------------------------------------------
    always_comb begin
        case (aluOpClass)
            CLASS_ADD:   op = ADD;
            CLASS_SUB:   op = SUB;
            CLASS_PASSB: op = PASSB;
            default: begin
                // funct7b5 arrives pre-qualified, so ADDI never subtracts
                case (funct3)
                    3'b000:  op = funct7b5 ? SUB : ADD;
                    3'b001:  op = SLL;
                    3'b010:  op = SLT;
                    3'b100:  op = XOR;
                    3'b101:  op = funct7b5 ? SRA : SRL;
                    3'b110:  op = OR;
                    3'b111:  op = AND;
                    default: op = ADD;
                endcase
            end
        endcase
    end

    // ------------------------------------------------------------------------
    // Compute
    // ------------------------------------------------------------------------
    always_comb begin
        case (op)
            ADD:     result = a + b;
            SUB:     result = a - b;
            AND:     result = a & b;
            OR:      result = a | b;
            XOR:     result = a ^ b;
            SLT:     result = {31'b0, $signed(a) < $signed(b)};
            SLL:     result = a << b[4:0];
            SRL:     result = a >> b[4:0];
            SRA:     result = word'($signed(a) >>> b[4:0]);
            PASSB:   result = b;
            default: result = '0;
        endcase
    end

    // BEQ taken on equal operands
    assign zero = (result == '0);

endmodule

// File: verilog/regFile.sv
`timescale 1ns/1ps

module regFile import riscvPkg::*; (
    input  logic   clk,
    input  logic   rst,
    input  regAddr raddr1,
    input  regAddr raddr2,
    input  regAddr waddr,
    input  word    wdata,
    input  logic   we,
    output word    rdata1,
    output word    rdata2,
    output word    a7
);

    word regs [32];

    // Two async read ports
    assign rdata1 = regs[raddr1];
    assign rdata2 = regs[raddr2];

    // Service code tap for ECALL
    assign a7 = regs[17];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

endmodule

// File: verilog/immGen.sv
`timescale 1ns/1ps

module immGen import riscvPkg::*; (
    input  word inst,
    output word imm
);

    logic [6:0] opcode;

    assign opcode = inst[6:0];

    always_comb begin
        case (opcode)
            // I format, also loads, JALR and SYSTEM
            OPCODE_I, OPCODE_L, OPCODE_JALR, OPCODE_E:
                imm = {{20{inst[31]}}, inst[31:20]};
            // S format
            OPCODE_S:
                imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
            // B format, halfword offset
            OPCODE_B:
                imm = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
            // J format
            OPCODE_JAL:
                imm = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
            // U format, upper 20 bits
            OPCODE_LUI, OPCODE_AUIPC:
                imm = {inst[31:12], 12'b0};
            // R format has no immediate
            default:
                imm = '0;
        endcase
    end

endmodule

// File: verilog/controller.sv
`timescale 1ns/1ps

module controller import riscvPkg::*; (
    input  word        inst,
    input  word        aluResult,
    input  logic       zero,
    input  word        ecallCode,
    output ctrlSignals ctrl,
    output logic [11:0] ecallOp
);

    logic [6:0]  opcode;
    logic [11:0] imm12;
    logic        isLoad;
    logic        isStore;
    logic        ioHit;
    logic        isEcall;

    assign opcode  = inst[6:0];
    assign imm12   = inst[31:20];
    assign isLoad  = (opcode == OPCODE_L);
    assign isStore = (opcode == OPCODE_S);
    assign isEcall = (opcode == OPCODE_E) && (imm12 == INST_ECALL);

    // Address falls in the switch/LED window
    assign ioHit = (aluResult[31:8] == IO_PREFIX);

    always_comb begin
        ctrl = '0;

        // Control flow
        ctrl.branch = (opcode == OPCODE_B) && zero;
        ctrl.jump   = (opcode == OPCODE_JAL);
        ctrl.jalr   = (opcode == OPCODE_JALR);

        // ALU class
        if (isLoad || isStore || opcode == OPCODE_AUIPC || ctrl.jump || ctrl.jalr) begin
            ctrl.aluOpClass = CLASS_ADD;
        end else if (opcode == OPCODE_B) begin
            ctrl.aluOpClass = CLASS_SUB;
        end else if (opcode == OPCODE_LUI) begin
            ctrl.aluOpClass = CLASS_PASSB;
        end else begin
            ctrl.aluOpClass = CLASS_FUNCT;
        end

        ctrl.aluSrc = (opcode == OPCODE_I) || isLoad || isStore ||
                      (opcode == OPCODE_LUI) || (opcode == OPCODE_AUIPC);

        // RAM only outside the I/O window
        ctrl.memRead  = isLoad && !ioHit;
        ctrl.memWrite = isStore && !ioHit;
        ctrl.memToReg = isLoad;
        ctrl.ioRead   = isLoad && ioHit;
        ctrl.ioWrite  = isStore && ioHit;

        ctrl.regWrite = (opcode == OPCODE_R) || (opcode == OPCODE_I) || isLoad ||
                        (opcode == OPCODE_LUI) || (opcode == OPCODE_AUIPC) ||
                        ctrl.jump || ctrl.jalr;

        ctrl.eBreak = (opcode == OPCODE_E) && (imm12 == INST_EBREAK);

        // Console service picked by a7
        if (isEcall) begin
            case (ecallCode[11:0])
                EOP_PRINT_INT: ctrl.eWrite = 1'b1;
                EOP_READ_INT:  ctrl.eRead  = 1'b1;
                default:       ;
            endcase
        end
    end

    assign ecallOp = ecallCode[11:0];

endmodule

// File: verilog/riscvPkg.sv
package riscvPkg;

    // ------------------------------------------------------------------------
    // Basic widths
    // ------------------------------------------------------------------------
    typedef logic [31:0] word;
    typedef logic [4:0]  regAddr;

    // ------------------------------------------------------------------------
    // RV32I opcodes
    // ------------------------------------------------------------------------
    localparam logic [6:0] OPCODE_R     = 7'b0110011;
    localparam logic [6:0] OPCODE_I     = 7'b0010011;
    localparam logic [6:0] OPCODE_L     = 7'b0000011;
    localparam logic [6:0] OPCODE_S     = 7'b0100011;
    localparam logic [6:0] OPCODE_B     = 7'b1100011;
    localparam logic [6:0] OPCODE_JAL   = 7'b1101111;
    localparam logic [6:0] OPCODE_JALR  = 7'b1100111;
    localparam logic [6:0] OPCODE_LUI   = 7'b0110111;
    localparam logic [6:0] OPCODE_AUIPC = 7'b0010111;
    localparam logic [6:0] OPCODE_E     = 7'b1110011;

    // SYSTEM imm12 field tells ECALL from EBREAK
    localparam logic [11:0] INST_ECALL  = 12'h000;
    localparam logic [11:0] INST_EBREAK = 12'h001;

    // Console services, selected through a7
    localparam logic [11:0] EOP_PRINT_INT = 12'd1;
    localparam logic [11:0] EOP_READ_INT  = 12'd5;

    // Upper address bits of the I/O window
    localparam logic [23:0] IO_PREFIX = 24'hFFFFFC;

    // ALU operation class, controller to ALU
    localparam logic [1:0] CLASS_ADD   = 2'b00;
    localparam logic [1:0] CLASS_SUB   = 2'b01;
    localparam logic [1:0] CLASS_FUNCT = 2'b10;
    localparam logic [1:0] CLASS_PASSB = 2'b11;

    typedef enum logic [3:0] {
        ADD, SUB, AND, OR, XOR, SLT, SLL, SRL, SRA, PASSB
    } aluOp;

    // ------------------------------------------------------------------------
    // Datapath controls
    // ------------------------------------------------------------------------
    typedef struct packed {
        logic       branch;
        logic       jump;
        logic       jalr;
        logic [1:0] aluOpClass;
        logic       aluSrc;
        logic       memRead;
        logic       memWrite;
        logic       memToReg;
        logic       regWrite;
        logic       ioRead;
        logic       ioWrite;
        logic       eRead;
        logic       eWrite;
        logic       eBreak;
    } ctrlSignals;

    // One console word, either direction
    typedef struct packed {
        logic valid;
        word  data;
    } consoleBeat;

endpackage
